/* mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// ==================================================
// core sizing
// ==================================================

// architectural register count, register 0 reads as zero
`define MIPS_NUM_REGS 32

// data memory depth in 32-bit words
`define MIPS_DMEM_WORDS 256

// instruction memory depth in 32-bit words
// the memory itself sits outside the core
`define MIPS_IMEM_WORDS 256

`endif

/* isaPkg.sv */
`default_nettype none

package isaPkg;

    // ==================================================
    // basic widths
    // ==================================================

    typedef logic [31:0] word_t;     // data or instruction word
    typedef logic [4:0]  regAddr_t;  // register index

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BEQ   = 6'b000100,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    // funct codes for the R-type group
    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } funct_e;

    // ==================================================
    // instruction layout
    // ==================================================

    // low half is either rd/shamt/funct or the immediate
    typedef struct packed {
        opcode_e  opcode;
        regAddr_t rs;
        regAddr_t rt;
        union packed {
            struct packed {
                regAddr_t   rd;
                logic [4:0] shamt;  // not used by this subset
                funct_e     funct;
            } r;
            logic [15:0] imm16;
        } low;
    } instrFields_t;

endpackage

`default_nettype wire

/* ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // alu operation class chosen by the decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10   // look at funct
    } aluOp_e;

    // function actually run by the alu
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } aluFunc_e;

    // decoder output, 9 bits
    typedef struct packed {
        logic   regDst;
        logic   aluSrc;
        logic   memToReg;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        aluOp_e aluOp;
    } ctrl_t;

    // architectural effects of the instruction retiring this cycle
    typedef struct packed {
        logic             valid;
        logic             regWe;
        isaPkg::regAddr_t regAddr;
        isaPkg::word_t    regData;
        logic             memWe;
        isaPkg::word_t    memAddr;
        isaPkg::word_t    memData;
    } retire_t;

endpackage

`default_nettype wire

/* ControlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module ControlUnit (
    input  wire isaPkg::opcode_e opcode,
    output ctrlPkg::ctrl_t       ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    // ==================================================
    // main decoder
    // ==================================================

    always_comb begin
        ctrl = '0;  // unknown opcodes leave everything inactive
        case (opcode)
            OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_FUNCT;
            end
            OP_LW: begin
                ctrl.aluSrc   = 1'b1;  // base + offset
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluOp    = ALUOP_ADD;
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = ALUOP_ADD;
            end
            OP_BEQ: begin
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = ALUOP_SUB;  // compare by subtracting
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // a memory access is either a load or a store, never both
    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("ControlUnit: memRead and memWrite both set");
    end

endmodule

`default_nettype wire

/* FetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module FetchUnit (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire logic          branchTaken,
    input  wire isaPkg::word_t branchOffset,  // sign-extended imm16, in words
    output isaPkg::word_t      pc
);
    import isaPkg::*;

    word_t seqPc;
    word_t targetPc;
    word_t nextPc;

    assign seqPc    = pc + 32'd4;
    assign targetPc = seqPc + {branchOffset[29:0], 2'b00};
    assign nextPc   = branchTaken ? targetPc : seqPc;

    // program counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // only word fetches are possible in this core
    pcAligned: assert property (
        @(posedge clk) disable iff (!arstN)
        pc[1:0] == 2'b00
    ) else $error("FetchUnit: pc not word aligned");

endmodule

`default_nettype wire

/* RegisterFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module RegisterFile (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire isaPkg::regAddr_t rsAddr,
    input  wire isaPkg::regAddr_t rtAddr,
    input  wire isaPkg::regAddr_t wrAddr,
    input  wire logic             wrEn,
    input  wire isaPkg::word_t    wrData,
    output isaPkg::word_t         rsData,
    output isaPkg::word_t         rtData
);
    import isaPkg::*;

    word_t regs [`MIPS_NUM_REGS];

    // ==================================================
    // write port
    // ==================================================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin  // $0 is never written
            regs[wrAddr] <= wrData;
        end
    end

    // ==================================================
    // read ports
    // ==================================================

    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

/* AluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module AluUnit (
    input  wire ctrlPkg::aluOp_e aluOp,
    input  wire isaPkg::funct_e  funct,
    input  wire logic            aluSrc,
    input  wire isaPkg::word_t   opA,
    input  wire isaPkg::word_t   regB,
    input  wire logic [15:0]     imm16,
    output isaPkg::word_t        result,
    output logic                 zero
);
    import isaPkg::*;
    import ctrlPkg::*;

    aluFunc_e aluFunc;
    word_t    opB;

    // ==================================================
    // alu control
    // ==================================================

    always_comb begin
        case (aluOp)
            ALUOP_ADD: aluFunc = ALU_ADD;
            ALUOP_SUB: aluFunc = ALU_SUB;
            ALUOP_FUNCT: begin
                case (funct)
                    FN_ADD:  aluFunc = ALU_ADD;
                    FN_SUB:  aluFunc = ALU_SUB;
                    FN_AND:  aluFunc = ALU_AND;
                    FN_OR:   aluFunc = ALU_OR;
                    FN_SLT:  aluFunc = ALU_SLT;
                    default: aluFunc = ALU_ADD;  // unknown funct behaves as add
                endcase
            end
            default: aluFunc = ALU_ADD;
        endcase
    end

    assign opB = aluSrc ? {{16{imm16[15]}}, imm16} : regB;

    // ==================================================
    // datapath
    // ==================================================

    always_comb begin
        case (aluFunc)
            ALU_AND: result = opA & opB;
            ALU_OR:  result = opA | opB;
            ALU_SUB: result = opA - opB;
            ALU_SLT: result = {31'd0, $signed(opA) < $signed(opB)};  // signed compare
            default: result = opA + opB;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* DataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module DataMemory (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire logic          wrEn,
    input  wire isaPkg::word_t addr,
    input  wire isaPkg::word_t wrData,
    output isaPkg::word_t      rdData
);
    import isaPkg::*;

    localparam int IdxW = $clog2(`MIPS_DMEM_WORDS);

    word_t             mem [`MIPS_DMEM_WORDS];
    logic [IdxW-1:0]   idx;

    assign idx = addr[IdxW+1:2];  // byte address to word index

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[idx] <= wrData;
        end
    end

    assign rdData = mem[idx];  // combinational read

    // stores come from sw only, so the address is a word address
    wrAligned: assert property (
        @(posedge clk) disable iff (!arstN)
        wrEn |-> (addr[1:0] == 2'b00)
    ) else $error("DataMemory: unaligned store to %h", addr);

endmodule

`default_nettype wire

/* MipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module MipsCore (
    input  wire logic          clk,
    input  wire logic          arstN,
    output isaPkg::word_t      imemAddr,
    input  wire isaPkg::word_t imemData,
    output ctrlPkg::retire_t   retire
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrFields_t instr;
    ctrl_t        ctrl;
    word_t        pc;
    word_t        rsData;
    word_t        rtData;
    word_t        aluResult;
    word_t        memRdData;
    word_t        wbData;
    word_t        immExt;
    regAddr_t     wrAddr;
    logic         aluZero;

    assign instr    = instrFields_t'(imemData);
    assign imemAddr = pc;
    assign immExt   = {{16{instr.low.imm16[15]}}, instr.low.imm16};

    // ==================================================
    // input side
    // ==================================================

    FetchUnit uFetch (
        .clk          (clk),
        .arstN        (arstN),
        .branchTaken  (ctrl.branch & aluZero),
        .branchOffset (immExt),
        .pc           (pc)
    );

    ControlUnit uCtrl (
        .opcode (instr.opcode),
        .ctrl   (ctrl)
    );

    // ==================================================
    // processing
    // ==================================================

    assign wrAddr = ctrl.regDst ? instr.low.r.rd : instr.rt;

    RegisterFile uRegs (
        .clk    (clk),
        .arstN  (arstN),
        .rsAddr (instr.rs),
        .rtAddr (instr.rt),
        .wrAddr (wrAddr),
        .wrEn   (ctrl.regWrite),
        .wrData (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    AluUnit uAlu (
        .aluOp  (ctrl.aluOp),
        .funct  (instr.low.r.funct),
        .aluSrc (ctrl.aluSrc),
        .opA    (rsData),
        .regB   (rtData),
        .imm16  (instr.low.imm16),
        .result (aluResult),
        .zero   (aluZero)
    );

    // ==================================================
    // output side
    // ==================================================

    DataMemory uDmem (
        .clk    (clk),
        .arstN  (arstN),
        .wrEn   (ctrl.memWrite),
        .addr   (aluResult),
        .wrData (rtData),
        .rdData (memRdData)
    );

    assign wbData = ctrl.memToReg ? memRdData : aluResult;

    // effects of the instruction that commits at the coming edge
    assign retire.valid   = arstN;
    assign retire.regWe   = arstN & ctrl.regWrite;
    assign retire.regAddr = wrAddr;
    assign retire.regData = wbData;
    assign retire.memWe   = arstN & ctrl.memWrite;
    assign retire.memAddr = aluResult;
    assign retire.memData = rtData;

endmodule

`default_nettype wire

/* tbMipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module tbMipsCore;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int ImemIdxW   = $clog2(`MIPS_IMEM_WORDS);
    localparam int DmemIdxW   = $clog2(`MIPS_DMEM_WORDS);
    localparam int CycleLimit = 4000;  // about 80 program cycles and 7 resets, wide margin

    logic    clk;
    logic    arstN;
    word_t   imemAddr;
    word_t   imemData;
    retire_t retire;

    word_t   imem [`MIPS_IMEM_WORDS];
    word_t   prog [$];                 // program under construction
    word_t   seedVal [`MIPS_IMEM_WORDS];
    logic    seedEn [`MIPS_IMEM_WORDS];
    word_t   seedWord;
    word_t   refRegs [`MIPS_NUM_REGS];
    word_t   refMem [`MIPS_DMEM_WORDS];
    word_t   refPc;
    logic [31:0] lfsr;
    int      errCount;
    int      checkCount;
    int      cycleCount;

    MipsCore dut (
        .clk      (clk),
        .arstN    (arstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .retire   (retire)
    );

    assign imemData = imem[imemAddr[ImemIdxW+1:2]];  // combinational instruction memory

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: no end of tests after %0d cycles", cycleCount);
            $display("Test failures found");
            $finish;
        end
    end

    // ==================================================
    // helpers
    // ==================================================

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t rType(input funct_e fn, input regAddr_t rd, input regAddr_t rs,
                                    input regAddr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input regAddr_t rt, input regAddr_t rs,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input regAddr_t got, input regAddr_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < `MIPS_IMEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'd0;  // zero is add $0,$0,$0
        end
        prog.delete();
    endtask

    // sw to a fixed address, its store data is forced onto rtData
    task automatic storeSeed(input word_t value, input logic [15:0] addr);
        int idx;
        idx          = prog.size();
        seedVal[idx] = value;
        seedEn[idx]  = 1'b1;
        prog.push_back(iType(OP_SW, 5'd0, 5'd0, addr));
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        #1;
        checkBit("retire.valid", retire.valid, 1'b0);
        checkBit("retire.regWe", retire.regWe, 1'b0);
        checkBit("retire.memWe", retire.memWe, 1'b0);
        checkWord("imemAddr", imemAddr, 32'd0);
        for (int i = 0; i < `MIPS_IMEM_WORDS; i++) begin
            seedEn[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;
        refPc = '0;
        for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
            refMem[i] = '0;
        end
    endtask

    // ==================================================
    // reference model, one instruction per call
    // ==================================================

    task automatic checkCycle(input logic seeded);
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      expData;
        word_t      expAddr;
        word_t      nextPc;
        regAddr_t   expReg;
        logic       expRegWe;
        logic       expMemWe;
        instr    = imem[refPc[ImemIdxW+1:2]];
        sext     = {{16{instr[15]}}, instr[15:0]};
        a        = refRegs[instr[25:21]];
        b        = seeded ? seedWord : refRegs[instr[20:16]];
        expRegWe = 1'b0;
        expMemWe = 1'b0;
        expReg   = instr[20:16];
        expData  = '0;
        expAddr  = a + sext;
        nextPc   = refPc + 32'd4;
        case (instr[31:26])
            OP_RTYPE: begin
                expRegWe = 1'b1;
                expReg   = instr[15:11];
                case (instr[5:0])
                    FN_SUB:  expData = a - b;
                    FN_AND:  expData = a & b;
                    FN_OR:   expData = a | b;
                    FN_SLT:  expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: expData = a + b;
                endcase
            end
            OP_LW: begin
                expRegWe = 1'b1;
                expData  = refMem[expAddr[DmemIdxW+1:2]];
            end
            OP_SW:   expMemWe = 1'b1;
            OP_BEQ:  if (a == b) nextPc = refPc + 32'd4 + (sext << 2);
            default: expRegWe = 1'b0;  // unsupported, nothing retires
        endcase
        checkWord("imemAddr", imemAddr, refPc);
        checkBit("retire.valid", retire.valid, 1'b1);
        checkBit("retire.regWe", retire.regWe, expRegWe);
        checkBit("retire.memWe", retire.memWe, expMemWe);
        if (expRegWe) begin
            checkAddr("retire.regAddr", retire.regAddr, expReg);
            checkWord("retire.regData", retire.regData, expData);
            if (expReg != '0) refRegs[expReg] = expData;
        end
        if (expMemWe) begin
            checkWord("retire.memAddr", retire.memAddr, expAddr);
            checkWord("retire.memData", retire.memData, b);
            refMem[expAddr[DmemIdxW+1:2]] = b;
        end
        refPc = nextPc;
    endtask

    task automatic runCycles(input int n);
        logic seeded;
        repeat (n) begin
            seeded = seedEn[refPc[ImemIdxW+1:2]];
            if (seeded) begin
                seedWord = seedVal[refPc[ImemIdxW+1:2]];
                force dut.rtData = seedWord;
            end
            #6;  // one ns before the edge
            checkCycle(seeded);
            @(posedge clk);
            #1;
            if (seeded) begin
                release dut.rtData;
            end
        end
    endtask

    task automatic runProgram();
        int len;
        len = prog.size();
        loadProgram();
        runCycles(len + 2);
    endtask

    // ==================================================
    // tests
    // ==================================================

    task automatic testRType();
        word_t v;
        applyReset();
        for (int i = 0; i < 6; i++) begin
            v = randBits(32);
            if (i == 2) v[31] = 1'b1;  // negative operand for slt
            storeSeed(v, 16'(i * 4));
        end
        for (int i = 0; i < 6; i++) begin
            prog.push_back(iType(OP_LW, regAddr_t'(i + 1), 5'd0, 16'(i * 4)));
        end
        prog.push_back(rType(FN_OR, 5'd7, 5'd0, 5'd0));
        prog.push_back(rType(FN_ADD, 5'd8, 5'd1, 5'd7));
        prog.push_back(rType(FN_ADD, 5'd10, 5'd1, 5'd2));
        prog.push_back(rType(FN_SUB, 5'd11, 5'd3, 5'd4));
        prog.push_back(rType(FN_AND, 5'd12, 5'd5, 5'd6));
        prog.push_back(rType(FN_OR, 5'd13, 5'd2, 5'd8));
        prog.push_back(rType(FN_SLT, 5'd14, 5'd3, 5'd1));
        prog.push_back(rType(FN_SLT, 5'd15, 5'd1, 5'd3));
        prog.push_back(rType(FN_SUB, 5'd16, 5'd4, 5'd4));
        runProgram();
    endtask

    task automatic testLoadStore();
        word_t v;
        word_t addrs [4];
        applyReset();
        for (int i = 0; i < 4; i++) begin
            v        = randBits(8);
            addrs[i] = {22'd0, v[7:0], 2'b00};
            storeSeed(randBits(32), addrs[i][15:0]);
        end
        for (int i = 0; i < 4; i++) begin
            prog.push_back(iType(OP_LW, regAddr_t'(i + 1), 5'd0, addrs[i][15:0]));
        end
        // store data now comes from the register file
        for (int i = 0; i < 4; i++) begin
            prog.push_back(iType(OP_SW, regAddr_t'(i + 1), 5'd0, 16'(16'h0100 + i * 4)));
        end
        for (int i = 0; i < 4; i++) begin
            prog.push_back(iType(OP_LW, regAddr_t'(i + 5), 5'd0, 16'(16'h0100 + i * 4)));
        end
        runProgram();
    endtask

    task automatic testBranch();
        word_t v;
        applyReset();
        v = randBits(32);
        storeSeed(v, 16'd0);
        storeSeed(v ^ 32'd1, 16'd4);
        prog.push_back(iType(OP_LW, 5'd1, 5'd0, 16'd0));
        prog.push_back(iType(OP_LW, 5'd2, 5'd0, 16'd0));
        prog.push_back(iType(OP_LW, 5'd3, 5'd0, 16'd4));
        prog.push_back(iType(OP_BEQ, 5'd2, 5'd1, 16'd2));    // equal, skips two
        prog.push_back(rType(FN_ADD, 5'd4, 5'd1, 5'd1));
        prog.push_back(rType(FN_ADD, 5'd5, 5'd1, 5'd1));
        prog.push_back(iType(OP_BEQ, 5'd3, 5'd1, 16'd5));    // unequal, falls through
        prog.push_back(rType(FN_ADD, 5'd6, 5'd1, 5'd3));
        prog.push_back(iType(OP_BEQ, 5'd0, 5'd0, 16'hfffe)); // backward loop
        runProgram();
    endtask

    task automatic testUnknownOpcode();
        applyReset();
        storeSeed(randBits(32), 16'd8);
        prog.push_back(iType(OP_LW, 5'd1, 5'd0, 16'd8));
        prog.push_back(iType(6'b001000, 5'd1, 5'd1, 16'h0004));  // addi
        prog.push_back(iType(6'b000010, 5'd1, 5'd0, 16'hffff));  // j
        prog.push_back(iType(6'b111111, 5'd2, 5'd1, 16'h1234));
        prog.push_back(rType(FN_ADD, 5'd3, 5'd1, 5'd0));
        runProgram();
    endtask

    task automatic testRegZero();
        applyReset();
        storeSeed(randBits(32), 16'd12);
        prog.push_back(iType(OP_LW, 5'd0, 5'd0, 16'd12));
        prog.push_back(iType(OP_LW, 5'd1, 5'd0, 16'd12));
        prog.push_back(rType(FN_ADD, 5'd0, 5'd1, 5'd1));
        prog.push_back(rType(FN_ADD, 5'd2, 5'd0, 5'd0));
        prog.push_back(rType(FN_ADD, 5'd3, 5'd0, 5'd1));
        runProgram();
    endtask

    task automatic testReset();
        applyReset();
        storeSeed(randBits(32), 16'd0);
        storeSeed(randBits(32), 16'd4);
        prog.push_back(iType(OP_LW, 5'd1, 5'd0, 16'd0));
        prog.push_back(iType(OP_LW, 5'd2, 5'd0, 16'd4));
        prog.push_back(rType(FN_ADD, 5'd3, 5'd1, 5'd2));
        loadProgram();
        runCycles(4);  // stop before the add
        applyReset();
        prog.push_back(rType(FN_ADD, 5'd4, 5'd1, 5'd0));
        prog.push_back(rType(FN_OR, 5'd5, 5'd2, 5'd3));
        prog.push_back(iType(OP_LW, 5'd6, 5'd0, 16'd4));
        runProgram();
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        seedWord   = '0;
        lfsr       = 32'hf2d0_057f;
        errCount   = 0;
        checkCount = 0;
        cycleCount = 0;
        loadProgram();
        testRType();
        testLoadStore();
        testBranch();
        testUnknownOpcode();
        testRegZero();
        testReset();
        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
isaPkg.sv
ctrlPkg.sv
ControlUnit.sv
FetchUnit.sv
RegisterFile.sv
AluUnit.sv
DataMemory.sv
MipsCore.sv
tbMipsCore.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbMipsCore
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
